// ==== include/sfa_consts.svh ====
`ifndef SFA_CONSTS_SVH
`define SFA_CONSTS_SVH

// stream word width
`define SFA_DATA_W 32
`define SFA_ROUTE_W 4
`define SFA_NUM_UNITS 5

`endif

// ==== logic/sfa_stream_pkg.sv ====
`default_nettype none

`include "sfa_consts.svh"

package sfa_stream_pkg;

  typedef logic [`SFA_DATA_W-1:0] sfa_data_t;

  // codes 6 to 15 are left unnamed and block every path
  typedef enum logic [`SFA_ROUTE_W-1:0] {
    ROUTE_OFF    = 4'd0,
    ROUTE_INC    = 4'd1,
    ROUTE_NEG    = 4'd2,
    ROUTE_BSWAP  = 4'd3,
    ROUTE_SQR16  = 4'd4,
    ROUTE_POPCNT = 4'd5
  } sfa_route_e;

  typedef enum logic [2:0] {
    OP_INC,
    OP_NEG,
    OP_BSWAP,
    OP_SQR16,
    OP_POPCNT
  } sfa_op_e;

endpackage

`default_nettype wire

// ==== logic/sfa_ctrl_pkg.sv ====
`default_nettype none

package sfa_ctrl_pkg;

  // route control
  typedef enum logic {
    CFG_IDLE,
    CFG_PENDING
  } sfa_cfg_state_e;

endpackage

`default_nettype wire

// ==== logic/sfa_1to5_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfa_1to5_demux
  import sfa_stream_pkg::*;
(
  input  sfa_route_e route,
  input  wire        route_hold,
  input  wire        s_tvalid,
  input  sfa_data_t  s_tdata,
  output logic       s_tready,
  output logic       u1_tvalid,
  output sfa_data_t  u1_tdata,
  input  wire        u1_tready,
  output logic       u2_tvalid,
  output sfa_data_t  u2_tdata,
  input  wire        u2_tready,
  output logic       u3_tvalid,
  output sfa_data_t  u3_tdata,
  input  wire        u3_tready,
  output logic       u4_tvalid,
  output sfa_data_t  u4_tdata,
  input  wire        u4_tready,
  output logic       u5_tvalid,
  output sfa_data_t  u5_tdata,
  input  wire        u5_tready
);

  logic open_path;

  // a pending route change closes the input
  assign open_path = ~route_hold;

  always_comb begin
    u1_tvalid = 1'b0;
    u2_tvalid = 1'b0;
    u3_tvalid = 1'b0;
    u4_tvalid = 1'b0;
    u5_tvalid = 1'b0;
    u1_tdata  = '0;
    u2_tdata  = '0;
    u3_tdata  = '0;
    u4_tdata  = '0;
    u5_tdata  = '0;
    s_tready  = 1'b0;
    case (route)
      ROUTE_INC: begin
        u1_tvalid = s_tvalid & open_path;
        u1_tdata  = s_tdata;
        s_tready  = u1_tready & open_path;
      end
      ROUTE_NEG: begin
        u2_tvalid = s_tvalid & open_path;
        u2_tdata  = s_tdata;
        s_tready  = u2_tready & open_path;
      end
      ROUTE_BSWAP: begin
        u3_tvalid = s_tvalid & open_path;
        u3_tdata  = s_tdata;
        s_tready  = u3_tready & open_path;
      end
      ROUTE_SQR16: begin
        u4_tvalid = s_tvalid & open_path;
        u4_tdata  = s_tdata;
        s_tready  = u4_tready & open_path;
      end
      ROUTE_POPCNT: begin
        u5_tvalid = s_tvalid & open_path;
        u5_tdata  = s_tdata;
        s_tready  = u5_tready & open_path;
      end
      // off and unnamed codes
      default: begin
        s_tready = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/sfa_5to1_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfa_5to1_mux
  import sfa_stream_pkg::*;
(
  output logic       s1_tready,
  input  wire        s1_tvalid,
  input  sfa_data_t  s1_tdata,
  output logic       s2_tready,
  input  wire        s2_tvalid,
  input  sfa_data_t  s2_tdata,
  output logic       s3_tready,
  input  wire        s3_tvalid,
  input  sfa_data_t  s3_tdata,
  output logic       s4_tready,
  input  wire        s4_tvalid,
  input  sfa_data_t  s4_tdata,
  output logic       s5_tready,
  input  wire        s5_tvalid,
  input  sfa_data_t  s5_tdata,
  input  wire        m_tready,
  output logic       m_tvalid,
  output sfa_data_t  m_tdata,
  input  sfa_route_e route
);

  always_comb begin
    // nothing selected unless the route names a unit
    m_tvalid  = 1'b0;
    m_tdata   = '0;
    s1_tready = 1'b0;
    s2_tready = 1'b0;
    s3_tready = 1'b0;
    s4_tready = 1'b0;
    s5_tready = 1'b0;
    case (route)
      ROUTE_INC: begin
        m_tvalid  = s1_tvalid;
        m_tdata   = s1_tdata;
        s1_tready = m_tready;
      end
      ROUTE_NEG: begin
        m_tvalid  = s2_tvalid;
        m_tdata   = s2_tdata;
        s2_tready = m_tready;
      end
      ROUTE_BSWAP: begin
        m_tvalid  = s3_tvalid;
        m_tdata   = s3_tdata;
        s3_tready = m_tready;
      end
      ROUTE_SQR16: begin
        m_tvalid  = s4_tvalid;
        m_tdata   = s4_tdata;
        s4_tready = m_tready;
      end
      ROUTE_POPCNT: begin
        m_tvalid  = s5_tvalid;
        m_tdata   = s5_tdata;
        s5_tready = m_tready;
      end
      default: begin
        m_tvalid = 1'b0;
        m_tdata  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/sfa_stream_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfa_stream_alu
  import sfa_stream_pkg::*;
#(
  parameter sfa_op_e op = OP_INC
) (
  input  wire       aclk,
  input  wire       rst_n,
  input  wire       s_tvalid,
  input  sfa_data_t s_tdata,
  output logic      s_tready,
  output logic      m_tvalid,
  output sfa_data_t m_tdata,
  input  wire       m_tready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operation applied to each accepted word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic sfa_data_t apply_op(input sfa_data_t d);
    sfa_data_t lo;
    sfa_data_t cnt;
    lo  = {16'd0, d[15:0]};
    cnt = '0;
    case (op)
      OP_INC:   apply_op = d + 1'b1;
      OP_NEG:   apply_op = ~d + 1'b1;
      OP_BSWAP: apply_op = {d[7:0], d[15:8], d[23:16], d[31:24]};
      OP_SQR16: apply_op = lo * lo;
      default: begin
        for (int i = 0; i < $bits(sfa_data_t); i++) begin
          cnt = cnt + d[i];
        end
        apply_op = cnt;
      end
    endcase
  endfunction

  logic take;

  // empty, or the held result leaves this cycle
  assign s_tready = ~m_tvalid | m_tready;
  assign take     = s_tvalid & s_tready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_tvalid <= 1'b0;
    end else if (take) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      m_tdata <= apply_op(s_tdata);
    end
  end

endmodule

`default_nettype wire

// ==== logic/sfa_route_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sfa_consts.svh"

module sfa_route_ctrl
  import sfa_stream_pkg::*;
  import sfa_ctrl_pkg::*;
(
  input  wire                       aclk,
  input  wire                       rst_n,
  input  wire                       conf_wr,
  input  sfa_route_e                conf_data,
  input  wire [`SFA_NUM_UNITS-1:0]  unit_busy,
  output sfa_route_e                route,
  output logic                      route_hold
);

  sfa_cfg_state_e state;
  sfa_route_e     pend_route;

  // later write overwrites the earlier one
  always_ff @(posedge aclk) begin
    if (conf_wr) begin
      pend_route <= conf_data;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CFG_IDLE;
      route <= ROUTE_OFF;
    end else begin
      case (state)
        CFG_IDLE: begin
          if (conf_wr) begin
            state <= CFG_PENDING;
          end
        end
        CFG_PENDING: begin
          // switch only once no unit holds a result
          if (!conf_wr && !(|unit_busy)) begin
            route <= pend_route;
            state <= CFG_IDLE;
          end
        end
      endcase
    end
  end

  assign route_hold = (state == CFG_PENDING);

endmodule

`default_nettype wire

// ==== logic/sfa_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sfa_consts.svh"

module sfa_fabric
  import sfa_stream_pkg::*;
(
  input  wire        aclk,
  input  wire        rst_n,
  input  wire        s_tvalid,
  input  sfa_data_t  s_tdata,
  output logic       s_tready,
  output logic       m_tvalid,
  output sfa_data_t  m_tdata,
  input  wire        m_tready,
  input  wire        conf_wr,
  input  sfa_route_e conf_data,
  output logic       cfg_busy
);

  sfa_route_e route;
  logic       route_hold;

  // distributor side of each unit
  logic       in1_tvalid, in2_tvalid, in3_tvalid, in4_tvalid, in5_tvalid;
  logic       in1_tready, in2_tready, in3_tready, in4_tready, in5_tready;
  sfa_data_t  in1_tdata, in2_tdata, in3_tdata, in4_tdata, in5_tdata;

  // selector side of each unit
  logic       out1_tvalid, out2_tvalid, out3_tvalid, out4_tvalid, out5_tvalid;
  logic       out1_tready, out2_tready, out3_tready, out4_tready, out5_tready;
  sfa_data_t  out1_tdata, out2_tdata, out3_tdata, out4_tdata, out5_tdata;

  logic [`SFA_NUM_UNITS-1:0] unit_busy;

  assign unit_busy = {out5_tvalid, out4_tvalid, out3_tvalid, out2_tvalid, out1_tvalid};
  assign cfg_busy  = route_hold;

  sfa_route_ctrl u_ctrl (
    .aclk(aclk), .rst_n(rst_n),
    .conf_wr(conf_wr), .conf_data(conf_data), .unit_busy(unit_busy),
    .route(route), .route_hold(route_hold)
  );

  sfa_1to5_demux u_demux (
    .route(route), .route_hold(route_hold),
    .s_tvalid(s_tvalid), .s_tdata(s_tdata), .s_tready(s_tready),
    .u1_tvalid(in1_tvalid), .u1_tdata(in1_tdata), .u1_tready(in1_tready),
    .u2_tvalid(in2_tvalid), .u2_tdata(in2_tdata), .u2_tready(in2_tready),
    .u3_tvalid(in3_tvalid), .u3_tdata(in3_tdata), .u3_tready(in3_tready),
    .u4_tvalid(in4_tvalid), .u4_tdata(in4_tdata), .u4_tready(in4_tready),
    .u5_tvalid(in5_tvalid), .u5_tdata(in5_tdata), .u5_tready(in5_tready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // function units, one per route code
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  sfa_stream_alu #(.op(OP_INC)) u_inc (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(in1_tvalid), .s_tdata(in1_tdata), .s_tready(in1_tready),
    .m_tvalid(out1_tvalid), .m_tdata(out1_tdata), .m_tready(out1_tready)
  );

  sfa_stream_alu #(.op(OP_NEG)) u_neg (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(in2_tvalid), .s_tdata(in2_tdata), .s_tready(in2_tready),
    .m_tvalid(out2_tvalid), .m_tdata(out2_tdata), .m_tready(out2_tready)
  );

  sfa_stream_alu #(.op(OP_BSWAP)) u_bswap (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(in3_tvalid), .s_tdata(in3_tdata), .s_tready(in3_tready),
    .m_tvalid(out3_tvalid), .m_tdata(out3_tdata), .m_tready(out3_tready)
  );

  sfa_stream_alu #(.op(OP_SQR16)) u_sqr16 (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(in4_tvalid), .s_tdata(in4_tdata), .s_tready(in4_tready),
    .m_tvalid(out4_tvalid), .m_tdata(out4_tdata), .m_tready(out4_tready)
  );

  sfa_stream_alu #(.op(OP_POPCNT)) u_popcnt (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(in5_tvalid), .s_tdata(in5_tdata), .s_tready(in5_tready),
    .m_tvalid(out5_tvalid), .m_tdata(out5_tdata), .m_tready(out5_tready)
  );

  sfa_5to1_mux u_mux (
    .s1_tready(out1_tready), .s1_tvalid(out1_tvalid), .s1_tdata(out1_tdata),
    .s2_tready(out2_tready), .s2_tvalid(out2_tvalid), .s2_tdata(out2_tdata),
    .s3_tready(out3_tready), .s3_tvalid(out3_tvalid), .s3_tdata(out3_tdata),
    .s4_tready(out4_tready), .s4_tvalid(out4_tvalid), .s4_tdata(out4_tdata),
    .s5_tready(out5_tready), .s5_tvalid(out5_tvalid), .s5_tdata(out5_tdata),
    .m_tready(m_tready), .m_tvalid(m_tvalid), .m_tdata(m_tdata),
    .route(route)
  );

endmodule

`default_nettype wire

// ==== tb/sfa_fabric_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sfa_consts.svh"

module sfa_fabric_asserts
  import sfa_stream_pkg::*;
  import sfa_ctrl_pkg::*;
(
  input wire                      aclk,
  input wire                      rst_n,
  input sfa_route_e               route,
  input sfa_cfg_state_e           state,
  input wire                      route_hold,
  input wire                      s_tready,
  input wire                      m_tvalid,
  input sfa_data_t                m_tdata,
  input wire                      m_tready,
  input wire                      in1_tvalid,
  input wire                      in2_tvalid,
  input wire                      in3_tvalid,
  input wire                      in4_tvalid,
  input wire                      in5_tvalid,
  input wire [`SFA_NUM_UNITS-1:0] unit_busy
);

  int unsigned fail_count = 0;

  // a stalled result must not move
  stall_stable: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata))
  ) else begin
    fail_count++;
    $error("m_tvalid or m_tdata changed while the output was stalled");
  end

  hold_blocks_input: assert property (
    @(posedge aclk) disable iff (!rst_n)
    route_hold |-> !s_tready
  ) else begin
    fail_count++;
    $error("s_tready high while a route change is pending");
  end

  one_unit_fed: assert property (
    @(posedge aclk) disable iff (!rst_n)
    $onehot0({in5_tvalid, in4_tvalid, in3_tvalid, in2_tvalid, in1_tvalid})
  ) else begin
    fail_count++;
    $error("more than one function unit offered input");
  end

  // the switch edge saw a pending write and every unit empty
  switch_when_empty: assert property (
    @(posedge aclk) disable iff (!rst_n)
    (route != $past(route)) |-> ($past(state) == CFG_PENDING && $past(unit_busy) == '0)
  ) else begin
    fail_count++;
    $error("route changed while a function unit held a result");
  end

endmodule

bind sfa_fabric sfa_fabric_asserts u_asserts (
  .aclk(aclk),
  .rst_n(rst_n),
  .route(route),
  .state(u_ctrl.state),
  .route_hold(route_hold),
  .s_tready(s_tready),
  .m_tvalid(m_tvalid),
  .m_tdata(m_tdata),
  .m_tready(m_tready),
  .in1_tvalid(in1_tvalid),
  .in2_tvalid(in2_tvalid),
  .in3_tvalid(in3_tvalid),
  .in4_tvalid(in4_tvalid),
  .in5_tvalid(in5_tvalid),
  .unit_busy(unit_busy)
);

`default_nettype wire

// ==== tb/sfa_fabric_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfa_fabric_tb
  import sfa_stream_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 4000;

  logic       aclk;
  logic       rst_n;
  logic       s_tvalid;
  sfa_data_t  s_tdata;
  logic       s_tready;
  logic       m_tvalid;
  sfa_data_t  m_tdata;
  logic       m_tready;
  logic       conf_wr;
  sfa_route_e conf_data;
  logic       cfg_busy;

  sfa_route_e  model_route;
  sfa_data_t   next_word;
  sfa_data_t   exp_q[$];
  int unsigned acc_q[$];
  logic        check_latency;
  int unsigned cycle = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  sfa_fabric uut (
    .aclk(aclk), .rst_n(rst_n),
    .s_tvalid(s_tvalid), .s_tdata(s_tdata), .s_tready(s_tready),
    .m_tvalid(m_tvalid), .m_tdata(m_tdata), .m_tready(m_tready),
    .conf_wr(conf_wr), .conf_data(conf_data), .cfg_busy(cfg_busy)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic sfa_data_t expected_word(input sfa_route_e r, input sfa_data_t d);
    logic [15:0] lo;
    sfa_data_t   res;
    lo  = d[15:0];
    res = '0;
    case (r)
      ROUTE_INC:    res = d + 32'd1;
      ROUTE_NEG:    res = 32'd0 - d;
      ROUTE_BSWAP: begin
        for (int b = 0; b < 4; b++) begin
          res[8*b +: 8] = d[8*(3-b) +: 8];
        end
      end
      ROUTE_SQR16:  res = 32'(lo) * 32'(lo);
      ROUTE_POPCNT: res = 32'($countones(d));
      default:      res = '0;
    endcase
    return res;
  endfunction

  task automatic check_data(input string name, input sfa_data_t got, input sfa_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_route(input string name, input sfa_route_e got, input sfa_route_e exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one clock cycle of stimulus plus scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_cycle(input logic valid, input sfa_data_t data, input logic ready,
                           input logic wr, input sfa_route_e cdata, output logic accepted);
    sfa_data_t   exp_word;
    int unsigned acc_cycle;
    @(negedge aclk);
    s_tvalid  = valid;
    s_tdata   = data;
    m_tready  = ready;
    conf_wr   = wr;
    conf_data = cdata;
    // outputs settle well before the next rising edge
    #1;
    accepted = valid & s_tready;
    if (m_tvalid && ready) begin
      if (exp_q.size() == 0) begin
        $display("output word 0x%08h left the fabric with nothing outstanding", m_tdata);
        errors++;
      end else begin
        exp_word  = exp_q.pop_front();
        acc_cycle = acc_q.pop_front();
        check_data("m_tdata", m_tdata, exp_word);
        if (check_latency && cycle != acc_cycle + 1) begin
          $display("output came %0d cycles after acceptance instead of 1", cycle - acc_cycle);
          errors++;
        end
      end
    end
    if (accepted) begin
      exp_q.push_back(expected_word(model_route, data));
      acc_q.push_back(cycle);
    end
  endtask

  task automatic write_route(input sfa_route_e r);
    logic acc;
    int   n;
    run_cycle(1'b0, '0, 1'b1, 1'b1, r, acc);
    run_cycle(1'b0, '0, 1'b1, 1'b0, r, acc);
    check_flag("cfg_busy", cfg_busy, 1'b1);
    n = 0;
    while (cfg_busy && n < 50) begin
      run_cycle(1'b0, '0, 1'b1, 1'b0, r, acc);
      n++;
    end
    if (cfg_busy) begin
      $display("cfg_busy did not fall within 50 cycles of a route write");
      errors++;
    end
    model_route = r;
  endtask

  task automatic stream_words(input int n, input logic toggle_ready);
    logic acc;
    logic ready;
    int   sent;
    int   k;
    sent = 0;
    k    = 0;
    while (sent < n && k < 10 * n) begin
      ready = toggle_ready ? k[0] : 1'b1;
      run_cycle(1'b1, next_word, ready, 1'b0, ROUTE_OFF, acc);
      if (acc) begin
        sent++;
        next_word = $urandom;
      end
      k++;
    end
    if (sent < n) begin
      $display("only %0d of %0d words were accepted", sent, n);
      errors++;
    end
  endtask

  task automatic drain_outputs();
    logic acc;
    int   n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      run_cycle(1'b0, '0, 1'b1, 1'b0, ROUTE_OFF, acc);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected words never left the fabric", exp_q.size());
      errors++;
      exp_q.delete();
      acc_q.delete();
    end
    // a duplicate would show up here
    run_cycle(1'b0, '0, 1'b1, 1'b0, ROUTE_OFF, acc);
    check_flag("m_tvalid", m_tvalid, 1'b0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic after_reset();
    int unsigned e0;
    logic        acc;
    e0 = errors;
    run_cycle(1'b0, '0, 1'b1, 1'b0, ROUTE_OFF, acc);
    check_flag("s_tready", s_tready, 1'b0);
    check_flag("m_tvalid", m_tvalid, 1'b0);
    check_flag("cfg_busy", cfg_busy, 1'b0);
    check_route("route", uut.route, ROUTE_OFF);
    finish_test("after_reset", e0);
  endtask

  task automatic each_route();
    int unsigned e0;
    e0 = errors;
    for (int r = 1; r <= 5; r++) begin
      write_route(sfa_route_e'(r));
      check_route("route", uut.route, sfa_route_e'(r));
      check_latency = 1'b1;
      stream_words(20, 1'b0);
      drain_outputs();
      check_latency = 1'b0;
    end
    finish_test("each_route", e0);
  endtask

  task automatic back_pressure();
    int unsigned e0;
    logic        acc;
    sfa_data_t   held;
    e0 = errors;
    write_route(ROUTE_BSWAP);
    held = expected_word(ROUTE_BSWAP, next_word);
    run_cycle(1'b1, next_word, 1'b0, 1'b0, ROUTE_OFF, acc);
    check_flag("s_tready", s_tready, 1'b1);
    if (acc) begin
      next_word = $urandom;
    end
    run_cycle(1'b1, next_word, 1'b0, 1'b0, ROUTE_OFF, acc);
    check_flag("m_tvalid", m_tvalid, 1'b1);
    check_data("m_tdata", m_tdata, held);
    repeat (6) begin
      run_cycle(1'b1, next_word, 1'b0, 1'b0, ROUTE_OFF, acc);
      check_flag("s_tready", s_tready, 1'b0);
      check_flag("m_tvalid", m_tvalid, 1'b1);
      check_data("m_tdata", m_tdata, held);
    end
    stream_words(12, 1'b1);
    drain_outputs();
    finish_test("back_pressure", e0);
  endtask

  task automatic reconfig_in_flight();
    int unsigned e0;
    logic        acc;
    int          n;
    e0 = errors;
    // park one result in the bswap unit
    run_cycle(1'b1, next_word, 1'b0, 1'b0, ROUTE_OFF, acc);
    check_flag("s_tready", s_tready, 1'b1);
    if (acc) begin
      next_word = $urandom;
    end
    run_cycle(1'b1, next_word, 1'b0, 1'b1, ROUTE_NEG, acc);
    check_flag("s_tready", s_tready, 1'b0);
    repeat (4) begin
      run_cycle(1'b1, next_word, 1'b0, 1'b0, ROUTE_OFF, acc);
      check_flag("cfg_busy", cfg_busy, 1'b1);
      check_flag("s_tready", s_tready, 1'b0);
      check_flag("m_tvalid", m_tvalid, 1'b1);
    end
    run_cycle(1'b1, next_word, 1'b1, 1'b0, ROUTE_OFF, acc);
    check_flag("cfg_busy", cfg_busy, 1'b1);
    check_flag("s_tready", s_tready, 1'b0);
    model_route = ROUTE_NEG;
    n = 0;
    while (!acc && n < 10) begin
      run_cycle(1'b1, next_word, 1'b1, 1'b0, ROUTE_OFF, acc);
      if (cfg_busy) begin
        check_flag("s_tready", s_tready, 1'b0);
      end
      n++;
    end
    if (!acc) begin
      $display("input stayed blocked after the stalled result was taken");
      errors++;
    end
    next_word = $urandom;
    check_route("route", uut.route, ROUTE_NEG);
    stream_words(10, 1'b0);
    drain_outputs();
    finish_test("reconfig_in_flight", e0);
  endtask

  task automatic blocking_codes();
    int unsigned e0;
    logic        acc;
    e0 = errors;
    for (int c = 0; c < 16; c++) begin
      if (c >= 1 && c <= 5) begin
        continue;
      end
      write_route(sfa_route_e'(c));
      check_route("route", uut.route, sfa_route_e'(c));
      repeat (3) begin
        run_cycle(1'b1, next_word, 1'b1, 1'b0, ROUTE_OFF, acc);
        check_flag("s_tready", s_tready, 1'b0);
        check_flag("m_tvalid", m_tvalid, 1'b0);
      end
    end
    run_cycle(1'b0, '0, 1'b1, 1'b0, ROUTE_OFF, acc);
    finish_test("blocking_codes", e0);
  endtask

  initial begin
    s_tvalid      = 1'b0;
    s_tdata       = '0;
    m_tready      = 1'b0;
    conf_wr       = 1'b0;
    conf_data     = ROUTE_OFF;
    rst_n         = 1'b0;
    model_route   = ROUTE_OFF;
    check_latency = 1'b0;
    void'($urandom(39));
    next_word = $urandom;
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    after_reset();
    each_route();
    back_pressure();
    reconfig_in_flight();
    blocking_codes();

    errors += uut.u_asserts.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sfa_fabric.f ====
+incdir+include
logic/sfa_stream_pkg.sv
logic/sfa_ctrl_pkg.sv
logic/sfa_1to5_demux.sv
logic/sfa_5to1_mux.sv
logic/sfa_stream_alu.sv
logic/sfa_route_ctrl.sv
logic/sfa_fabric.sv
tb/sfa_fabric_asserts.sv
tb/sfa_fabric_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sfa_fabric_tb
FILELIST  ?= sfa_fabric.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
